/* dnn_cfg_pkg.sv */
package dnn_cfg_pkg;

  // Array geometry
  localparam int ROWS = 4;    // Pixel rows per beat
  localparam int COLS = 4;    // Weight columns per beat

  // Arithmetic widths
  localparam int X_BITS = 8;
  localparam int K_BITS = 8;
  localparam int Y_BITS = 20;       // 16 product bits + 4 for 16 terms
  localparam int Y_PAD_BITS = 32;   // Output word after sign extension

  typedef logic signed [X_BITS-1:0] pixel_t;
  typedef logic signed [K_BITS-1:0] weight_t;
  typedef logic signed [Y_BITS-1:0] acc_t;
  typedef logic [Y_PAD_BITS-1:0] out_word_t;

endpackage

/* dnn_stream_pkg.sv */
package dnn_stream_pkg;

  localparam int K_MAX = 16;   // Deepest kernel block

  typedef logic [$clog2(K_MAX):0] depth_t;   // Holds 0 to K_MAX

  typedef logic [dnn_cfg_pkg::ROWS*dnn_cfg_pkg::X_BITS-1:0] pix_beat_t;
  typedef logic [dnn_cfg_pkg::COLS*dnn_cfg_pkg::K_BITS-1:0] wgt_beat_t;

  // Column c of the block starts at c*ROWS*Y_BITS
  typedef logic [dnn_cfg_pkg::ROWS*dnn_cfg_pkg::COLS*dnn_cfg_pkg::Y_BITS-1:0] res_t;

  typedef logic [dnn_cfg_pkg::ROWS*dnn_cfg_pkg::Y_PAD_BITS-1:0] out_beat_t;

  typedef enum logic [1:0] {
    EMPTY,
    LOAD,
    REPLAY
  } rot_state_t;

endpackage

/* dnn_stream_if.sv */
`timescale 1ns/1ns

interface dnn_stream_if #(
  parameter int DW = 32
) ();

  logic          valid;
  logic          ready;
  logic          last;
  logic [DW-1:0] data;

  modport src (
    output valid,
    output last,
    output data,
    input  ready
  );

  modport dst (
    input  valid,
    input  last,
    input  data,
    output ready
  );

endinterface

/* axis_pixels.sv */
`timescale 1ns/1ns

module axis_pixels (
  input  logic                       aclk,
  input  logic                       rst,
  input  logic                       s_valid,
  output logic                       s_ready,
  input  logic                       s_last,
  input  dnn_stream_pkg::pix_beat_t  s_data,
  dnn_stream_if.src                  m
);

  logic                      out_valid;
  logic                      out_last;
  dnn_stream_pkg::pix_beat_t out_data;
  logic                      skid_valid;
  logic                      skid_last;
  dnn_stream_pkg::pix_beat_t skid_data;
  logic                      out_load;

  assign s_ready  = !skid_valid;            // Registered ready
  assign out_load = m.ready || !out_valid;  // Output stage free this cycle

  always_ff @(posedge aclk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_load) begin
      out_valid  <= skid_valid || s_valid;
      skid_valid <= 1'b0;
    end else if (s_valid && s_ready) begin
      skid_valid <= 1'b1;                   // Park beat while output stalls
    end
  end

  always_ff @(posedge aclk) begin
    if (out_load) begin
      out_data <= skid_valid ? skid_data : s_data;
      out_last <= skid_valid ? skid_last : s_last;
    end
    if (s_ready) begin
      skid_data <= s_data;
      skid_last <= s_last;
    end
  end

  assign m.valid = out_valid;
  assign m.last  = out_last;
  assign m.data  = out_data;

endmodule

/* weight_rotator.sv */
`timescale 1ns/1ns

module weight_rotator (
  input  logic                       aclk,
  input  logic                       rst,
  input  logic                       s_valid,
  output logic                       s_ready,
  input  logic                       s_last,
  input  dnn_stream_pkg::wgt_beat_t  s_data,
  dnn_stream_if.src                  m
);

  localparam int AW = $clog2(dnn_stream_pkg::K_MAX);

  dnn_stream_pkg::rot_state_t state;
  dnn_stream_pkg::wgt_beat_t  mem [dnn_stream_pkg::K_MAX];
  dnn_stream_pkg::depth_t     wr_ptr;
  dnn_stream_pkg::depth_t     rd_ptr;
  dnn_stream_pkg::depth_t     depth;
  dnn_stream_pkg::depth_t     last_idx;
  dnn_stream_pkg::wgt_beat_t  out_data;
  logic                       out_valid;
  logic                       out_last;
  logic                       out_first;
  logic                       at_start;
  logic                       s_fire;
  logic                       fetch;

  assign last_idx = dnn_stream_pkg::depth_t'(depth - 1'b1);

  // Between passes when nothing is held or beat 0 waits untaken
  assign at_start = !out_valid || out_first;
  assign s_ready  = (state != dnn_stream_pkg::REPLAY) || (at_start && !m.ready);
  assign s_fire   = s_valid && s_ready;
  assign fetch    = (state == dnn_stream_pkg::REPLAY) && !s_fire && (!out_valid || m.ready);

  always_ff @(posedge aclk) begin
    if (rst) begin
      state     <= dnn_stream_pkg::EMPTY;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      depth     <= '0;
      out_valid <= 1'b0;
    end else if (s_fire) begin
      out_valid <= 1'b0;                    // No output while loading
      if (s_last) begin
        state  <= dnn_stream_pkg::REPLAY;
        depth  <= dnn_stream_pkg::depth_t'(wr_ptr + 1'b1);
        wr_ptr <= '0;
        rd_ptr <= '0;
      end else begin
        state  <= dnn_stream_pkg::LOAD;
        wr_ptr <= dnn_stream_pkg::depth_t'(wr_ptr + 1'b1);
      end
    end else if (fetch) begin
      out_valid <= 1'b1;
      rd_ptr    <= (rd_ptr == last_idx) ? '0 : dnn_stream_pkg::depth_t'(rd_ptr + 1'b1);
    end
  end

  always_ff @(posedge aclk) begin
    if (s_fire) begin
      mem[wr_ptr[AW-1:0]] <= s_data;
    end
    if (fetch) begin
      out_data  <= mem[rd_ptr[AW-1:0]];     // Registered read
      out_last  <= (rd_ptr == last_idx);
      out_first <= (rd_ptr == '0);
    end
  end

  assign m.valid = out_valid;
  assign m.last  = out_last;
  assign m.data  = out_data;

endmodule

/* engine_ctrl.sv */
`timescale 1ns/1ns

module engine_ctrl (
  input  logic                       aclk,
  input  logic                       rst,
  dnn_stream_if.dst                  pix,
  dnn_stream_if.dst                  wgt,
  input  logic                       mac_ready,
  output logic                       fire,
  output logic                       first,
  output logic                       last_beat,
  output dnn_stream_pkg::pix_beat_t  pix_data,
  output dnn_stream_pkg::wgt_beat_t  wgt_data
);

  logic first_q;

  // A beat moves only when pixels, weights and the array all agree
  assign fire      = pix.valid && wgt.valid && mac_ready;
  assign pix.ready = fire;
  assign wgt.ready = fire;

  // Stored kernel depth defines the pass length
  assign last_beat = wgt.last;
  assign first     = first_q;
  assign pix_data  = pix.data;
  assign wgt_data  = wgt.data;

  always_ff @(posedge aclk) begin
    if (rst) begin
      first_q <= 1'b1;
    end else if (fire) begin
      first_q <= last_beat;                 // Next beat opens a pass
    end
  end

endmodule

/* mac_array.sv */
`timescale 1ns/1ns

module mac_array (
  input  logic                       aclk,
  input  logic                       rst,
  input  logic                       fire,
  input  logic                       first,
  input  logic                       last_beat,
  input  dnn_stream_pkg::pix_beat_t  pix_data,
  input  dnn_stream_pkg::wgt_beat_t  wgt_data,
  output logic                       mac_ready,
  dnn_stream_if.src                  res
);

  localparam int ROWS   = dnn_cfg_pkg::ROWS;
  localparam int COLS   = dnn_cfg_pkg::COLS;
  localparam int Y_BITS = dnn_cfg_pkg::Y_BITS;

  dnn_cfg_pkg::pixel_t  px  [ROWS];
  dnn_cfg_pkg::weight_t wt  [COLS];
  dnn_cfg_pkg::acc_t    acc [ROWS][COLS];
  dnn_cfg_pkg::acc_t    sum [ROWS][COLS];
  dnn_stream_pkg::res_t sum_flat;
  dnn_stream_pkg::res_t res_q;
  logic                 res_valid;

  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      px[r] = pix_data[r*dnn_cfg_pkg::X_BITS +: dnn_cfg_pkg::X_BITS];
    end
    for (int c = 0; c < COLS; c++) begin
      wt[c] = wgt_data[c*dnn_cfg_pkg::K_BITS +: dnn_cfg_pkg::K_BITS];
    end
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        // First beat of a pass starts from zero
        sum[r][c] = (first ? dnn_cfg_pkg::acc_t'(0) : acc[r][c]) + px[r] * wt[c];
        sum_flat[(c*ROWS + r)*Y_BITS +: Y_BITS] = sum[r][c];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (fire) begin
      acc <= sum;
    end
    if (fire && last_beat) begin
      res_q <= sum_flat;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else if (fire && last_beat) begin
      res_valid <= 1'b1;
    end else if (res.ready) begin
      res_valid <= 1'b0;
    end
  end

  // Only a finishing pass has to wait for the held block to drain
  assign mac_ready = !(res_valid && !res.ready && last_beat);

  assign res.valid = res_valid;
  assign res.last  = 1'b1;                  // One beat per block
  assign res.data  = res_q;

endmodule

/* out_shift.sv */
`timescale 1ns/1ns

module out_shift (
  input  logic                       aclk,
  input  logic                       rst,
  dnn_stream_if.dst                  s,
  output logic                       m_valid,
  input  logic                       m_ready,
  output logic                       m_last,
  output dnn_stream_pkg::out_beat_t  m_data
);

  localparam int ROWS   = dnn_cfg_pkg::ROWS;
  localparam int Y_BITS = dnn_cfg_pkg::Y_BITS;
  localparam int CW     = $clog2(dnn_cfg_pkg::COLS);

  dnn_stream_pkg::res_t blk;
  dnn_cfg_pkg::acc_t    y [ROWS];
  logic [CW-1:0]        col;
  logic                 col_last;
  logic                 busy;
  logic                 drain_end;

  assign col_last  = (col == CW'(dnn_cfg_pkg::COLS - 1));
  assign drain_end = busy && m_ready && col_last;
  assign s.ready   = !busy || drain_end;    // Take next block as last beat leaves

  always_ff @(posedge aclk) begin
    if (rst) begin
      busy <= 1'b0;
      col  <= '0;
    end else if (s.valid && s.ready) begin
      busy <= 1'b1;
      col  <= '0;
    end else if (busy && m_ready) begin
      busy <= !col_last;
      col  <= col_last ? '0 : CW'(col + 1'b1);
    end
  end

  // Column 0 sits in the low bits
  always_ff @(posedge aclk) begin
    if (s.valid && s.ready) begin
      blk <= s.data;
    end else if (busy && m_ready) begin
      blk <= blk >> (ROWS*Y_BITS);
    end
  end

  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      y[r] = blk[r*Y_BITS +: Y_BITS];
      m_data[r*dnn_cfg_pkg::Y_PAD_BITS +: dnn_cfg_pkg::Y_PAD_BITS] =
        dnn_cfg_pkg::out_word_t'(y[r]);     // Sign extend
    end
  end

  assign m_valid = busy;
  assign m_last  = col_last;

endmodule

/* dnn_engine.sv */
`timescale 1ns/1ns

module dnn_engine (
  input  logic                       aclk,
  input  logic                       rst,

  output logic                       s_axis_pixels_tready,
  input  logic                       s_axis_pixels_tvalid,
  input  logic                       s_axis_pixels_tlast,
  input  dnn_stream_pkg::pix_beat_t  s_axis_pixels_tdata,

  output logic                       s_axis_weights_tready,
  input  logic                       s_axis_weights_tvalid,
  input  logic                       s_axis_weights_tlast,
  input  dnn_stream_pkg::wgt_beat_t  s_axis_weights_tdata,

  input  logic                       m_axis_tready,
  output logic                       m_axis_tvalid,
  output logic                       m_axis_tlast,
  output dnn_stream_pkg::out_beat_t  m_axis_tdata
);

  logic                      fire;
  logic                      first;
  logic                      last_beat;
  logic                      mac_ready;
  dnn_stream_pkg::pix_beat_t pix_data;
  dnn_stream_pkg::wgt_beat_t wgt_data;

  dnn_stream_if #(.DW($bits(dnn_stream_pkg::pix_beat_t))) pix_if ();
  dnn_stream_if #(.DW($bits(dnn_stream_pkg::wgt_beat_t))) wgt_if ();
  dnn_stream_if #(.DW($bits(dnn_stream_pkg::res_t)))      res_if ();

  axis_pixels pixels (
    .aclk    (aclk),
    .rst     (rst),
    .s_valid (s_axis_pixels_tvalid),
    .s_ready (s_axis_pixels_tready),
    .s_last  (s_axis_pixels_tlast),
    .s_data  (s_axis_pixels_tdata),
    .m       (pix_if.src)
  );

  weight_rotator weights_rotator (
    .aclk    (aclk),
    .rst     (rst),
    .s_valid (s_axis_weights_tvalid),
    .s_ready (s_axis_weights_tready),
    .s_last  (s_axis_weights_tlast),
    .s_data  (s_axis_weights_tdata),
    .m       (wgt_if.src)
  );

  engine_ctrl ctrl (
    .aclk      (aclk),
    .rst       (rst),
    .pix       (pix_if.dst),
    .wgt       (wgt_if.dst),
    .mac_ready (mac_ready),
    .fire      (fire),
    .first     (first),
    .last_beat (last_beat),
    .pix_data  (pix_data),
    .wgt_data  (wgt_data)
  );

  mac_array mac (
    .aclk      (aclk),
    .rst       (rst),
    .fire      (fire),
    .first     (first),
    .last_beat (last_beat),
    .pix_data  (pix_data),
    .wgt_data  (wgt_data),
    .mac_ready (mac_ready),
    .res       (res_if.src)
  );

  out_shift out (
    .aclk    (aclk),
    .rst     (rst),
    .s       (res_if.dst),
    .m_valid (m_axis_tvalid),
    .m_ready (m_axis_tready),
    .m_last  (m_axis_tlast),
    .m_data  (m_axis_tdata)
  );

endmodule

/* tb_dnn_engine.sv */
`timescale 1ns/1ns

module tb_dnn_engine;

  localparam int ROWS  = dnn_cfg_pkg::ROWS;
  localparam int COLS  = dnn_cfg_pkg::COLS;
  localparam int XB    = dnn_cfg_pkg::X_BITS;
  localparam int KB    = dnn_cfg_pkg::K_BITS;
  localparam int YW    = dnn_cfg_pkg::Y_PAD_BITS;
  localparam int K_MAX = dnn_stream_pkg::K_MAX;
  // Input beats per test and output beats per test
  localparam int IN_BEATS  = 8 + 20 + 21 + 3 + 32 + 32 + 32 + 27;
  localparam int OUT_BEATS = 4 + 12 + 8 + 8 + 4 + 4 + 4 + 32;
  localparam int LIMIT     = 20 * (IN_BEATS + OUT_BEATS) + 200;

  logic aclk;
  logic rst;
  logic s_axis_pixels_tready;
  logic s_axis_pixels_tvalid;
  logic s_axis_pixels_tlast;
  dnn_stream_pkg::pix_beat_t s_axis_pixels_tdata;
  logic s_axis_weights_tready;
  logic s_axis_weights_tvalid;
  logic s_axis_weights_tlast;
  dnn_stream_pkg::wgt_beat_t s_axis_weights_tdata;
  logic m_axis_tready;
  logic m_axis_tvalid;
  logic m_axis_tlast;
  dnn_stream_pkg::out_beat_t m_axis_tdata;

  dnn_stream_pkg::wgt_beat_t kernel [K_MAX];
  dnn_stream_pkg::pix_beat_t pixels [K_MAX];
  int                        kernel_depth;
  dnn_stream_pkg::pix_beat_t pix_q [$];
  logic                      pix_last_q [$];
  dnn_stream_pkg::out_beat_t exp_q [$];
  int                        cycles;

  dnn_engine dut0 (
    .aclk                  (aclk),
    .rst                   (rst),
    .s_axis_pixels_tready  (s_axis_pixels_tready),
    .s_axis_pixels_tvalid  (s_axis_pixels_tvalid),
    .s_axis_pixels_tlast   (s_axis_pixels_tlast),
    .s_axis_pixels_tdata   (s_axis_pixels_tdata),
    .s_axis_weights_tready (s_axis_weights_tready),
    .s_axis_weights_tvalid (s_axis_weights_tvalid),
    .s_axis_weights_tlast  (s_axis_weights_tlast),
    .s_axis_weights_tdata  (s_axis_weights_tdata),
    .m_axis_tready         (m_axis_tready),
    .m_axis_tvalid         (m_axis_tvalid),
    .m_axis_tlast          (m_axis_tlast),
    .m_axis_tdata          (m_axis_tdata)
  );

  always #2 aclk = ~aclk;

  always @(posedge aclk) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("Simulation FAILED");
      $fatal(1, "Timeout");
    end
  end

  task check_value(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Kernel fill modes are random, all -128 and alternating 127 and -128 columns
  task fill_kernel(input int mode);
    for (int k = 0; k < kernel_depth; k++) begin
      for (int c = 0; c < COLS; c++) begin
        case (mode)
          0:       kernel[k][c*KB +: KB] = KB'($urandom);
          1:       kernel[k][c*KB +: KB] = 8'h80;
          default: kernel[k][c*KB +: KB] = (c % 2 == 0) ? 8'h7f : 8'h80;
        endcase
      end
    end
  endtask

  task compute_expected();
    int sum;
    dnn_stream_pkg::out_beat_t beat;
    for (int c = 0; c < COLS; c++) begin
      beat = '0;
      for (int r = 0; r < ROWS; r++) begin
        sum = 0;
        for (int k = 0; k < kernel_depth; k++) begin
          sum += $signed(pixels[k][r*XB +: XB]) * $signed(kernel[k][c*KB +: KB]);
        end
        beat[r*YW +: YW] = YW'(sum);            // 32-bit two's complement word
      end
      exp_q.push_back(beat);
    end
  endtask

  task queue_packet(input int mode);
    for (int k = 0; k < kernel_depth; k++) begin
      pixels[k] = (mode == 0) ? dnn_stream_pkg::pix_beat_t'($urandom) : {ROWS{8'h80}};
      pix_q.push_back(pixels[k]);
      pix_last_q.push_back(k == kernel_depth - 1);
    end
    compute_expected();
  endtask

  task send_weights();
    for (int k = 0; k < kernel_depth; k++) begin
      s_axis_weights_tvalid = 1'b1;
      s_axis_weights_tdata  = kernel[k];
      s_axis_weights_tlast  = (k == kernel_depth - 1);
      @(negedge aclk);
      while (!s_axis_weights_tready) @(negedge aclk);
      @(posedge aclk);                          // Transfer edge
      #1;
    end
    s_axis_weights_tvalid = 1'b0;
    s_axis_weights_tlast  = 1'b0;
  endtask

  task send_pixels();
    while (pix_q.size() > 0) begin
      s_axis_pixels_tvalid = 1'b1;
      s_axis_pixels_tdata  = pix_q.pop_front();
      s_axis_pixels_tlast  = pix_last_q.pop_front();
      @(negedge aclk);
      while (!s_axis_pixels_tready) @(negedge aclk);
      @(posedge aclk);
      #1;
    end
    s_axis_pixels_tvalid = 1'b0;
    s_axis_pixels_tlast  = 1'b0;
  endtask

  task collect_output(input int n_beats, input bit backpressure);
    int got;
    got = 0;
    while (got < n_beats) begin
      m_axis_tready = backpressure ? 1'($urandom) : 1'b1;
      @(negedge aclk);
      if (m_axis_tvalid && m_axis_tready) begin
        check_value("m_axis_tdata", m_axis_tdata, exp_q.pop_front());
        check_value("m_axis_tlast", m_axis_tlast, (got % COLS) == COLS - 1);
        got++;
      end
      @(posedge aclk);
      #1;
    end
    m_axis_tready = 1'b0;                       // Stray beats wait for the next check
  endtask

  task load_and_run(input int depth, input int kmode, input int pmode, input int n_pkts,
                    input bit backpressure);
    kernel_depth = depth;
    fill_kernel(kmode);
    send_weights();
    repeat (n_pkts) queue_packet(pmode);
    fork
      send_pixels();
      collect_output(n_pkts * COLS, backpressure);
    join
  endtask

  task apply_reset();
    rst = 1'b1;
    repeat (3) @(posedge aclk);
    #1;
    check_value("m_axis_tvalid", m_axis_tvalid, 1'b0);
    check_value("s_axis_pixels_tready", s_axis_pixels_tready, 1'b1);
    check_value("s_axis_weights_tready", s_axis_weights_tready, 1'b1);
    repeat (2) @(posedge aclk);
    #1;
    rst = 1'b0;
    @(posedge aclk);
    #1;
    check_value("m_axis_tvalid", m_axis_tvalid, 1'b0);
    check_value("s_axis_pixels_tready", s_axis_pixels_tready, 1'b1);
    check_value("s_axis_weights_tready", s_axis_weights_tready, 1'b1);
  endtask

  task single_pass();
    load_and_run(4, 0, 0, 1, 1'b0);
  endtask

  task weight_reuse();
    load_and_run(5, 0, 0, 3, 1'b0);
  endtask

  task kernel_reload();
    load_and_run(7, 0, 0, 2, 1'b0);
    load_and_run(1, 0, 0, 2, 1'b0);
    load_and_run(K_MAX, 0, 0, 1, 1'b0);
  endtask

  task signed_extremes();
    load_and_run(K_MAX, 1, 1, 1, 1'b0);         // 262144 in every word
    load_and_run(K_MAX, 2, 1, 1, 1'b0);
  endtask

  task random_stall_run();
    load_and_run(3, 0, 0, 8, 1'b1);
  endtask

  initial begin
    aclk                  = 1'b0;
    rst                   = 1'b1;
    cycles                = 0;
    s_axis_pixels_tvalid  = 1'b0;
    s_axis_pixels_tlast   = 1'b0;
    s_axis_pixels_tdata   = '0;
    s_axis_weights_tvalid = 1'b0;
    s_axis_weights_tlast  = 1'b0;
    s_axis_weights_tdata  = '0;
    m_axis_tready         = 1'b0;
    void'($urandom(32'hfef4));
    apply_reset();
    single_pass();
    weight_reuse();
    kernel_reload();
    signed_extremes();
    random_stall_run();
    repeat (10) @(posedge aclk);
    #1;
    check_value("m_axis_tvalid", m_axis_tvalid, 1'b0);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* verilog.f */
dnn_cfg_pkg.sv
dnn_stream_pkg.sv
dnn_stream_if.sv
axis_pixels.sv
weight_rotator.sv
engine_ctrl.sv
mac_array.sv
out_shift.sv
dnn_engine.sv
tb_dnn_engine.sv

/* Bender.yml */
package:
  name: dnn_engine

sources:
  - dnn_cfg_pkg.sv
  - dnn_stream_pkg.sv
  - dnn_stream_if.sv
  - axis_pixels.sv
  - weight_rotator.sv
  - engine_ctrl.sv
  - mac_array.sv
  - out_shift.sv
  - dnn_engine.sv
  - target: test
    files:
      - tb_dnn_engine.sv
